/* sources.f */
ex_pkg.sv
fu_req_if.sv
operand_sel.sv
alu.sv
branch_unit.sv
mult.sv
ex_stage.sv
ex_stage_sva.sv
ex_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module ex_stage_tb -f sources.f
./obj_dir/Vex_stage_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* ex_stage_tb.sv */
// ex_stage_tb module: clock, reset, xorshift stimulus, reference model and result checks
`timescale 1ns/100ps

module ex_stage_tb;
  import ex_pkg::*;

  localparam int bits_per_step = 4;
  localparam int mult_lat      = 64 / bits_per_step;
  localparam int num_issues    = 2000;
  localparam int max_cycles    = 40000;
  localparam int wait_limit    = 100;

  logic       clock;
  logic       rst;
  logic       issue_valid;
  logic       issue_ready;
  fu_t        fu;
  inst_word_t inst;
  word_t      npc;
  word_t      rega;
  word_t      regb;
  opa_sel_t   opa_sel;
  opb_sel_t   opb_sel;
  alu_func_t  func;
  logic       br_cond_en;
  logic       br_uncond;
  logic       alu_valid;
  word_t      alu_result;
  logic       br_valid;
  logic       br_taken;
  word_t      br_target;
  logic       mult_out_valid;
  logic       mult_out_ready;
  word_t      mult_result;

  // model state and counters
  logic [31:0] rng;
  int          cyc;
  int          errors;
  int          alu_checks;
  int          br_checks;
  int          mult_checks;
  int          accepted;
  int          waited;
  logic        exp_alu_valid;
  word_t       exp_alu_result;
  logic        exp_br_valid;
  logic        exp_br_taken;
  word_t       exp_br_target;
  word_t       mult_q[$];
  logic        mult_pending;
  int          acc_edge;

  ex_stage #(
    .bits_per_step (bits_per_step)
  ) dut_i (
    .clock          (clock),
    .rst            (rst),
    .issue_valid    (issue_valid),
    .issue_ready    (issue_ready),
    .fu             (fu),
    .inst           (inst),
    .npc            (npc),
    .rega           (rega),
    .regb           (regb),
    .opa_sel        (opa_sel),
    .opb_sel        (opb_sel),
    .func           (func),
    .br_cond_en     (br_cond_en),
    .br_uncond      (br_uncond),
    .alu_valid      (alu_valid),
    .alu_result     (alu_result),
    .br_valid       (br_valid),
    .br_taken       (br_taken),
    .br_target      (br_target),
    .mult_out_valid (mult_out_valid),
    .mult_out_ready (mult_out_ready),
    .mult_result    (mult_result)
  );

  // 8 ns clock
  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  ////////////////////
  // random source
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // biased toward zero, all-ones and sign edges
  function automatic word_t rand_word();
    logic [31:0] r;
    logic [31:0] hi;
    logic [31:0] lo;
    r  = next_rand();
    hi = next_rand();
    lo = next_rand();
    case (r[2:0])
      3'd0: return '0;
      3'd1: return '1;
      3'd2: return 64'h8000_0000_0000_0000;
      3'd3: return 64'h7fff_ffff_ffff_ffff;
      3'd4: return word_t'(r[15:8]);
      default: return {hi, lo};
    endcase
  endfunction

  ////////////////////
  // reference model
  ////////////////////

  function automatic word_t operand_a(input opa_sel_t sel, input inst_word_t iw,
                                      input word_t pc, input word_t ra);
    case (sel)
      opa_is_mem_disp: return word_t'($signed(iw[15:0]));
      opa_is_npc:      return pc;
      opa_is_not3:     return 64'hffff_ffff_ffff_fffc;
      default:         return ra;
    endcase
  endfunction

  function automatic word_t operand_b(input opb_sel_t sel, input inst_word_t iw,
                                      input word_t rb);
    case (sel)
      opb_is_alu_imm: return word_t'(iw[20:13]);
      // displacement counts words
      opb_is_br_disp: return word_t'($signed(iw[20:0])) * 64'd4;
      default:        return rb;
    endcase
  endfunction

  function automatic word_t alu_ref(input alu_func_t f, input word_t a, input word_t b);
    int sh;
    sh = int'(b[5:0]);
    case (f)
      alu_addq:   return a + b;
      alu_subq:   return a - b;
      alu_and:    return a & b;
      alu_bic:    return a & ~b;
      alu_bis:    return a | b;
      alu_ornot:  return a | ~b;
      alu_xor:    return a ^ b;
      alu_eqv:    return ~(a ^ b);
      alu_srl:    return a >> sh;
      alu_sll:    return a << sh;
      alu_sra:    return word_t'($signed(a) >>> sh);
      alu_cmpult: return word_t'(a < b);
      alu_cmpeq:  return word_t'(a == b);
      alu_cmpule: return word_t'(a <= b);
      alu_cmplt:  return word_t'($signed(a) < $signed(b));
      default:    return word_t'($signed(a) <= $signed(b));
    endcase
  endfunction

  // condition in bits 27:26, bit 28 flips it
  function automatic logic branch_taken(input inst_word_t iw, input word_t ra,
                                        input logic cond_en, input logic uncond);
    logic c;
    case (iw[27:26])
      2'd0: c = (ra[0] == 1'b0);
      2'd1: c = (ra == 64'd0);
      2'd2: c = ($signed(ra) < 0);
      default: c = ($signed(ra) <= 0);
    endcase
    if (iw[28])
      c = !c;
    return uncond || (cond_en && c);
  endfunction

  ////////////////////
  // stimulus and checks
  ////////////////////

  task automatic next_cycle();
    @(posedge clock);
    cyc = cyc + 1;
    #1;
  endtask

  task automatic report_value(input string what, input word_t got, input word_t exp);
    errors = errors + 1;
    $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
  endtask

  task automatic drive_issue();
    logic [31:0] r;
    r = next_rand();
    issue_valid = (r[3:0] != 4'd0);
    case (r[5:4])
      2'd2: fu = fu_branch;
      2'd3: fu = fu_mult;
      default: fu = fu_alu;
    endcase
    func    = alu_func_t'(r[9:6]);
    opa_sel = opa_sel_t'(r[11:10]);
    opb_sel = opb_sel_t'((r[13:12] == 2'd3) ? 2'd0 : r[13:12]);
    br_cond_en     = r[14];
    br_uncond      = r[15] & r[16];
    // ready low a quarter of the time
    mult_out_ready = (r[18:17] != 2'd0);
    inst = next_rand();
    npc  = rand_word();
    rega = rand_word();
    regb = rand_word();
    // branches always add npc and displacement
    if (fu == fu_branch) begin
      opa_sel = opa_is_npc;
      opb_sel = opb_is_br_disp;
    end
  endtask

  // mid-cycle, outputs of the last edge against the model
  task automatic check_cycle();
    logic  exp_ready;
    logic  exp_mvalid;
    logic  accept;
    word_t a;
    word_t b;
    word_t exp_prod;
    assert (alu_valid === exp_alu_valid)
      else report_value("alu_valid", word_t'(alu_valid), word_t'(exp_alu_valid));
    if (exp_alu_valid) begin
      alu_checks = alu_checks + 1;
      assert (alu_result === exp_alu_result)
        else report_value("alu_result", alu_result, exp_alu_result);
    end
    assert (br_valid === exp_br_valid)
      else report_value("br_valid", word_t'(br_valid), word_t'(exp_br_valid));
    if (exp_br_valid) begin
      br_checks = br_checks + 1;
      assert (br_taken === exp_br_taken)
        else report_value("br_taken", word_t'(br_taken), word_t'(exp_br_taken));
      assert (br_target === exp_br_target)
        else report_value("br_target", br_target, exp_br_target);
    end
    // exact latency, then held until taken
    exp_mvalid = mult_pending && (cyc >= acc_edge + mult_lat);
    assert (mult_out_valid === exp_mvalid)
      else report_value("mult_out_valid", word_t'(mult_out_valid), word_t'(exp_mvalid));
    exp_ready = (fu == fu_mult) ? !mult_pending : 1'b1;
    assert (issue_ready === exp_ready)
      else report_value("issue_ready", word_t'(issue_ready), word_t'(exp_ready));
    if (mult_out_valid && mult_out_ready) begin
      if (mult_q.size() == 0) begin
        errors = errors + 1;
        $display("multiply result delivered with none outstanding at %0t ns", $time);
      end else begin
        exp_prod    = mult_q.pop_front();
        mult_checks = mult_checks + 1;
        assert (mult_result === exp_prod)
          else report_value("mult_result", mult_result, exp_prod);
      end
      mult_pending = 1'b0;
    end
    // what the coming edge should produce
    a      = operand_a(opa_sel, inst, npc, rega);
    b      = operand_b(opb_sel, inst, regb);
    accept = issue_valid && exp_ready;
    exp_alu_valid  = accept && (fu == fu_alu);
    exp_alu_result = alu_ref(func, a, b);
    exp_br_valid   = accept && (fu == fu_branch);
    exp_br_taken   = branch_taken(inst, rega, br_cond_en, br_uncond);
    exp_br_target  = a + b;
    if (accept && fu == fu_mult) begin
      mult_q.push_back(a * b);
      mult_pending = 1'b1;
      acc_edge     = cyc + 1;
    end
    if (accept)
      accepted = accepted + 1;
  endtask

  initial begin
    rng            = 32'h12fb0fc7;
    cyc            = 0;
    errors         = 0;
    alu_checks     = 0;
    br_checks      = 0;
    mult_checks    = 0;
    accepted       = 0;
    waited         = 0;
    exp_alu_valid  = 1'b0;
    exp_alu_result = '0;
    exp_br_valid   = 1'b0;
    exp_br_taken   = 1'b0;
    exp_br_target  = '0;
    mult_pending   = 1'b0;
    acc_edge       = 0;
    rst            = 1'b1;
    issue_valid    = 1'b0;
    fu             = fu_mult;
    inst           = '0;
    npc            = '0;
    rega           = '0;
    regb           = '0;
    opa_sel        = opa_is_rega;
    opb_sel        = opb_is_regb;
    func           = alu_addq;
    br_cond_en     = 1'b0;
    br_uncond      = 1'b0;
    mult_out_ready = 1'b0;

    // two reset edges
    repeat (2) next_cycle();
    rst = 1'b0;
    @(negedge clock);
    assert (!alu_valid && !br_valid && !mult_out_valid)
      else report_value("valids after reset", {61'd0, alu_valid, br_valid, mult_out_valid},
                        '0);
    assert (issue_ready === 1'b1)
      else report_value("issue_ready after reset", word_t'(issue_ready), 64'd1);

    // random issue stream
    while (accepted < num_issues && cyc < max_cycles) begin
      next_cycle();
      drive_issue();
      @(negedge clock);
      check_cycle();
    end
    assert (accepted >= num_issues)
      else begin
        errors = errors + 1;
        $display("issue stream stalled, only %0d issues accepted", accepted);
      end

    // drain the last results, inputs change only after an edge
    while ((mult_pending || exp_alu_valid || exp_br_valid) && waited < wait_limit) begin
      next_cycle();
      issue_valid    = 1'b0;
      mult_out_ready = 1'b1;
      @(negedge clock);
      check_cycle();
      waited = waited + 1;
    end
    assert (!mult_pending && mult_q.size() == 0)
      else begin
        errors = errors + 1;
        $display("timeout: multiply result missing after %0d cycles", wait_limit);
      end

    $display("checks alu %0d, branch %0d, mult %0d; errors %0d",
             alu_checks, br_checks, mult_checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

/* ex_stage_sva.sv */
// ex_stage_sva module: reset and handshake assertions, bound into ex_stage
`timescale 1ns/100ps

module ex_stage_sva (
  input logic          clock,
  input logic          rst,
  input logic          issue_valid,
  input logic          issue_ready,
  input ex_pkg::fu_t   fu,
  input logic          alu_valid,
  input logic          br_valid,
  input logic          mult_out_valid,
  input logic          mult_out_ready,
  input ex_pkg::word_t mult_result
);
  import ex_pkg::*;

  logic mul_open;

  // a multiply is open from its acceptance to its result handshake
  always_ff @(posedge clock) begin
    if (rst)
      mul_open <= 1'b0;
    else if (issue_valid && issue_ready && fu == fu_mult)
      mul_open <= 1'b1;
    else if (mult_out_valid && mult_out_ready)
      mul_open <= 1'b0;
  end

  // reset clears every result valid
  reset_valids: assert property (@(posedge clock)
    rst |=> !alu_valid && !br_valid && !mult_out_valid)
    else $error("result valid high after a reset edge");

  // multiplier idle out of reset
  reset_ready: assert property (@(posedge clock) rst |=> issue_ready)
    else $error("issue_ready low after a reset edge");

  // held result under back-pressure
  held_result: assert property (@(posedge clock) disable iff (rst)
    mult_out_valid && !mult_out_ready |=> mult_out_valid && $stable(mult_result))
    else $error("multiply result dropped or changed while stalled");

  // no new multiply until the open one hands off its result
  no_overlap: assert property (@(posedge clock) disable iff (rst)
    mul_open |-> !(issue_valid && issue_ready && fu == fu_mult))
    else $error("multiply accepted while a result was pending");

endmodule

bind ex_stage ex_stage_sva sva_i (
  .clock          (clock),
  .rst            (rst),
  .issue_valid    (issue_valid),
  .issue_ready    (issue_ready),
  .fu             (fu),
  .alu_valid      (alu_valid),
  .br_valid       (br_valid),
  .mult_out_valid (mult_out_valid),
  .mult_out_ready (mult_out_ready),
  .mult_result    (mult_result)
);

/* ex_stage.sv */
// ex_stage module: operand select, alu, branch unit and multiplier dispatch
`timescale 1ns/100ps

module ex_stage #(
  parameter int bits_per_step = 4
) (
  input  logic               clock,
  input  logic               rst,
  // issue port
  input  logic               issue_valid,
  output logic               issue_ready,
  input  ex_pkg::fu_t        fu,
  input  ex_pkg::inst_word_t inst,
  input  ex_pkg::word_t      npc,
  input  ex_pkg::word_t      rega,
  input  ex_pkg::word_t      regb,
  input  ex_pkg::opa_sel_t   opa_sel,
  input  ex_pkg::opb_sel_t   opb_sel,
  input  ex_pkg::alu_func_t  func,
  input  logic               br_cond_en,
  input  logic               br_uncond,
  // alu result pulse
  output logic               alu_valid,
  output ex_pkg::word_t      alu_result,
  // branch result pulse
  output logic               br_valid,
  output logic               br_taken,
  output ex_pkg::word_t      br_target,
  // multiplier result
  output logic               mult_out_valid,
  input  logic               mult_out_ready,
  output ex_pkg::word_t      mult_result
);
  import ex_pkg::*;

  word_t opa;
  word_t opb;
  word_t alu_out;
  logic  alu_issue;

  fu_req_if br_req ();
  fu_req_if mul_req ();

  operand_sel operand_sel_i (
    .inst    (inst),
    .npc     (npc),
    .rega    (rega),
    .regb    (regb),
    .opa_sel (opa_sel),
    .opb_sel (opb_sel),
    .opa     (opa),
    .opb     (opb)
  );

  alu alu_i (
    .opa    (opa),
    .opb    (opb),
    .func   (func),
    .result (alu_out)
  );

  ////////////////////
  // dispatch
  ////////////////////

  // same payload to both units, valid by unit tag
  assign br_req.req_valid  = issue_valid && (fu == fu_branch);
  assign br_req.opa        = opa;
  assign br_req.opb        = opb;
  assign br_req.func       = func;
  assign br_req.inst       = inst;

  assign mul_req.req_valid = issue_valid && (fu == fu_mult);
  assign mul_req.opa       = opa;
  assign mul_req.opb       = opb;
  assign mul_req.func      = func;
  assign mul_req.inst      = inst;

  assign alu_issue = issue_valid && (fu == fu_alu);

  // ready of the addressed unit, alu always takes
  always_comb begin
    case (fu)
      fu_branch: issue_ready = br_req.req_ready;
      fu_mult:   issue_ready = mul_req.req_ready;
      default:   issue_ready = 1'b1;
    endcase
  end

  branch_unit branch_unit_i (
    .clock      (clock),
    .rst        (rst),
    .req        (br_req),
    .rega       (rega),
    .br_cond_en (br_cond_en),
    .br_uncond  (br_uncond),
    .valid      (br_valid),
    .taken      (br_taken),
    .target     (br_target)
  );

  mult #(
    .bits_per_step (bits_per_step)
  ) mult_i (
    .clock     (clock),
    .rst       (rst),
    .req       (mul_req),
    .out_valid (mult_out_valid),
    .out_ready (mult_out_ready),
    .product   (mult_result)
  );

  ////////////////////
  // alu result register
  ////////////////////

  always_ff @(posedge clock) begin
    if (rst)
      alu_valid <= 1'b0;
    else
      alu_valid <= alu_issue;
  end

  always_ff @(posedge clock) begin
    if (alu_issue)
      alu_result <= alu_out;
  end

endmodule

/* mult.sv */
// mult module: iterative shift-add multiplier fsm with valid/ready in and out
`timescale 1ns/100ps

module mult #(
  parameter int bits_per_step = 4
) (
  input  logic          clock,
  input  logic          rst,
  fu_req_if.unit        req,
  output logic          out_valid,
  input  logic          out_ready,
  output ex_pkg::word_t product
);
  import ex_pkg::*;

  // cycles per multiply
  localparam int steps = 64 / bits_per_step;
  localparam int cnt_w = (steps > 1) ? $clog2(steps) : 1;

  mult_state_t      state;
  logic [cnt_w-1:0] cnt;
  word_t            mcand;
  word_t            mplier;
  word_t            prod;
  word_t            step_sum;

  // accept only from idle
  assign req.req_ready = (state == idle);
  assign out_valid     = (state == done);
  assign product       = prod;

  // partial products for the low multiplier bits of this step
  always_comb begin
    step_sum = '0;
    for (int k = 0; k < bits_per_step; k++) begin
      if (mplier[k])
        step_sum = step_sum + (mcand << k);
    end
  end

  ////////////////////
  // control fsm
  ////////////////////

  always_ff @(posedge clock) begin
    if (rst) begin
      state <= idle;
      cnt   <= '0;
    end else begin
      case (state)
        idle: if (req.req_valid) begin
          state <= busy;
          cnt   <= cnt_w'(steps - 1);
        end
        // last step lands on cnt == 0
        busy: if (cnt == '0)
          state <= done;
        else
          cnt <= cnt - 1'b1;
        // hold result until taken
        done: if (out_ready)
          state <= idle;
        default: state <= idle;
      endcase
    end
  end

  ////////////////////
  // datapath
  ////////////////////

  always_ff @(posedge clock) begin
    if (state == idle && req.req_valid) begin
      mcand  <= req.opa;
      mplier <= req.opb;
      prod   <= '0;
    end else if (state == busy) begin
      // retire bits_per_step multiplier bits
      prod   <= prod + step_sum;
      mcand  <= mcand << bits_per_step;
      mplier <= mplier >> bits_per_step;
    end
  end

endmodule

/* branch_unit.sv */
// branch_unit module: condition test, target adder and registered taken decision
`timescale 1ns/100ps

module branch_unit (
  input  logic          clock,
  input  logic          rst,
  fu_req_if.unit        req,
  input  ex_pkg::word_t rega,
  input  logic          br_cond_en,
  input  logic          br_uncond,
  output logic          valid,
  output logic          taken,
  output ex_pkg::word_t target
);
  import ex_pkg::*;

  logic cond;

  // single cycle unit, never stalls
  assign req.req_ready = 1'b1;

  // condition from inst[28:26], bit 28 inverts
  always_comb begin
    case (req.inst[27:26])
      2'b00: cond = ~rega[0];
      2'b01: cond = (rega == '0);
      2'b10: cond = rega[63];
      default: cond = rega[63] | (rega == '0);
    endcase
    if (req.inst[28])
      cond = ~cond;
  end

  ////////////////////
  // result register
  ////////////////////

  always_ff @(posedge clock) begin
    if (rst)
      valid <= 1'b0;
    else
      valid <= req.req_valid & req.req_ready;
  end

  // payload, issuer put npc and br_disp on opa/opb
  always_ff @(posedge clock) begin
    taken  <= br_uncond | (br_cond_en & cond);
    target <= req.opa + req.opb;
  end

endmodule

/* alu.sv */
// alu module: combinational 64-bit integer alu with compares and shifts
`timescale 1ns/100ps

module alu (
  input  ex_pkg::word_t     opa,
  input  ex_pkg::word_t     opb,
  input  ex_pkg::alu_func_t func,
  output ex_pkg::word_t     result
);
  import ex_pkg::*;

  logic [5:0] shamt;
  word_t      sra_fill;

  // signed less-than, sign bits decide when they differ
  function automatic logic signed_lt(input word_t a, input word_t b);
    if (a[63] == b[63])
      return a < b;
    else
      return a[63];
  endfunction

  // only the low six bits count for shifts
  assign shamt = opb[5:0];

  // sign copies shifted into the vacated top bits
  // shamt of zero shifts them all out
  assign sra_fill = {64{opa[63]}} << (7'd64 - {1'b0, shamt});

  always_comb begin
    case (func)
      alu_addq:   result = opa + opb;
      alu_subq:   result = opa - opb;
      alu_and:    result = opa & opb;
      alu_bic:    result = opa & ~opb;
      alu_bis:    result = opa | opb;
      alu_ornot:  result = opa | ~opb;
      alu_xor:    result = opa ^ opb;
      alu_eqv:    result = opa ^ ~opb;
      alu_srl:    result = opa >> shamt;
      alu_sll:    result = opa << shamt;
      // arithmetic shift from the logical one
      alu_sra:    result = (opa >> shamt) | sra_fill;
      // compares give 0 or 1 in bit 0
      alu_cmpult: result = {63'd0, opa < opb};
      alu_cmpeq:  result = {63'd0, opa == opb};
      alu_cmpule: result = {63'd0, opa <= opb};
      alu_cmplt:  result = {63'd0, signed_lt(opa, opb)};
      alu_cmple:  result = {63'd0, signed_lt(opa, opb) || (opa == opb)};
      default:    result = '0;
    endcase
  end

endmodule

/* operand_sel.sv */
// operand_sel module: immediate extraction and a/b operand multiplexers
`timescale 1ns/100ps

module operand_sel (
  input  ex_pkg::inst_word_t inst,
  input  ex_pkg::word_t      npc,
  input  ex_pkg::word_t      rega,
  input  ex_pkg::word_t      regb,
  input  ex_pkg::opa_sel_t   opa_sel,
  input  ex_pkg::opb_sel_t   opb_sel,
  output ex_pkg::word_t      opa,
  output ex_pkg::word_t      opb
);
  import ex_pkg::*;

  word_t mem_disp;
  word_t br_disp;
  word_t alu_imm;

  ////////////////////
  // immediates
  ////////////////////

  // memory format, sign-extended 16 bits
  assign mem_disp = {{48{inst[15]}}, inst[15:0]};
  // branch format, 21 bits sign-extended, word aligned
  assign br_disp  = {{41{inst[20]}}, inst[20:0], 2'b00};
  // operate format literal, zero-extended
  assign alu_imm  = {56'd0, inst[20:13]};

  ////////////////////
  // operand muxes
  ////////////////////

  always_comb begin
    case (opa_sel)
      opa_is_rega:     opa = rega;
      opa_is_mem_disp: opa = mem_disp;
      opa_is_npc:      opa = npc;
      // mask for aligning jump targets
      opa_is_not3:     opa = ~64'h3;
      default:         opa = rega;
    endcase
  end

  always_comb begin
    case (opb_sel)
      opb_is_regb:    opb = regb;
      opb_is_alu_imm: opb = alu_imm;
      opb_is_br_disp: opb = br_disp;
      // spare code
      default:        opb = '0;
    endcase
  end

endmodule

/* fu_req_if.sv */
// fu_req_if interface: one operand request from the stage to a functional unit
`timescale 1ns/100ps

interface fu_req_if;
  import ex_pkg::*;

  // handshake
  logic req_valid;
  logic req_ready;

  // request payload, operands already selected
  word_t      opa;
  word_t      opb;
  alu_func_t  func;
  inst_word_t inst;

  // issue side
  modport stage (output req_valid, output opa, output opb, output func, output inst,
                 input req_ready);

  // unit side, only ready flows back
  modport unit (input req_valid, input opa, input opb, input func, input inst,
                output req_ready);

endinterface

/* ex_pkg.sv */
// execute stage package: word types, instruction field types, alu/select/unit/fsm enums
package ex_pkg;

  ////////////////////
  // data widths
  ////////////////////

  // 64-bit datapath word
  typedef logic [63:0] word_t;

  // raw instruction word as fetched
  typedef logic [31:0] inst_word_t;

  ////////////////////
  // alu function codes
  ////////////////////

  // 16 ops, fits 4 bits exactly
  typedef enum logic [3:0] {
    alu_addq,
    alu_subq,
    alu_and,
    alu_bic,
    alu_bis,
    alu_ornot,
    alu_xor,
    alu_eqv,
    alu_srl,
    alu_sll,
    alu_sra,
    alu_cmpult,
    alu_cmpeq,
    alu_cmpule,
    alu_cmplt,
    alu_cmple
  } alu_func_t;

  ////////////////////
  // operand selects
  ////////////////////

  // a side source
  typedef enum logic [1:0] {
    opa_is_rega,
    opa_is_mem_disp,
    opa_is_npc,
    opa_is_not3
  } opa_sel_t;

  // b side source, one code unused
  typedef enum logic [1:0] {
    opb_is_regb,
    opb_is_alu_imm,
    opb_is_br_disp
  } opb_sel_t;

  // which functional unit takes the issue
  typedef enum logic [1:0] {
    fu_alu,
    fu_branch,
    fu_mult
  } fu_t;

  // multiplier control states
  typedef enum logic [1:0] {
    idle,
    busy,
    done
  } mult_state_t;

endpackage
